//--- rtl/glay_pkg.sv
package glay_pkg;

  // ----------------------------------------------------------
  // Memory request commands
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    CMD_READ         = 2'b00,
    CMD_WRITE        = 2'b01,
    CMD_READ_STREAM  = 2'b10,
    CMD_WRITE_STREAM = 2'b11
  } mem_cmd_t;

  // ----------------------------------------------------------
  // Funnel controller states
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    ARB_SETUP = 2'b00,
    ARB_RUN   = 2'b01,
    ARB_HOLD  = 2'b10
  } arb_state_t;

  // ----------------------------------------------------------
  // Request field widths
  // ----------------------------------------------------------
  localparam int CMD_WIDTH    = $bits(mem_cmd_t);
  // One memory word each
  localparam int ADDR_WIDTH   = 32;
  localparam int DATA_WIDTH   = 32;
  // Requestor id
  localparam int SOURCE_WIDTH = 4;

  // Packed word as held in the FIFOs
  localparam int PACKET_WIDTH = CMD_WIDTH + SOURCE_WIDTH + ADDR_WIDTH + DATA_WIDTH;

  // Field positions inside the packed word, data in the low bits
  localparam int DATA_LSB   = 0;
  localparam int ADDR_LSB   = DATA_LSB + DATA_WIDTH;
  localparam int SOURCE_LSB = ADDR_LSB + ADDR_WIDTH;
  localparam int CMD_LSB    = SOURCE_LSB + SOURCE_WIDTH;

endpackage : glay_pkg

//--- rtl/request_fifo.sv
`timescale 1ns/1ns

module request_fifo #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic                              wr_en,
  input  logic                              rd_en,
  input  logic [glay_pkg::PACKET_WIDTH-1:0] din,
  output logic [glay_pkg::PACKET_WIDTH-1:0] dout,
  output logic                              valid,
  output logic                              empty,
  output logic                              full,
  output logic                              prog_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  // Storage
  logic [glay_pkg::PACKET_WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] clr_ptr;
  logic [CNT_W-1:0] count;
  logic             clearing;
  logic             wr_fire;
  logic             rd_fire;

  // ----------------------------------------------------------
  // Status flags
  // ----------------------------------------------------------
  // Looks full and empty while storage is being wiped
  assign empty     = clearing | (count == '0);
  assign full      = clearing | (count == CNT_W'(DEPTH));
  assign prog_full = (count >= CNT_W'(PROG_THRESH));

  // Strobes against a full or empty buffer are dropped here
  assign wr_fire = wr_en & ~full;
  assign rd_fire = rd_en & ~empty;

  // ----------------------------------------------------------
  // Post-reset clearing walk
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      clearing <= 1'b1;
      clr_ptr  <= '0;
    end else if (clearing) begin
      clr_ptr <= clr_ptr + 1'b1;
      // One slot per cycle, done after the last one
      if (clr_ptr == LAST_PTR) begin
        clearing <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave count alone
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count <= count - 1'b1;
      end
      // Read data valid one cycle after the pop
      valid <= rd_fire;
    end
  end

  // Storage write port, zero fill first
  always_ff @(posedge ap_clk) begin
    if (clearing) begin
      mem[clr_ptr] <= '0;
    end else if (wr_fire) begin
      mem[wr_ptr] <= din;
    end
  end

  // Registered read port
  always_ff @(posedge ap_clk) begin
    if (rd_fire) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule : request_fifo

//--- rtl/round_robin_arbiter.sv
`timescale 1ns/1ns

module round_robin_arbiter #(
  parameter int NUM_REQUESTORS = 4
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      enable,
  input  logic [NUM_REQUESTORS-1:0] request,
  output logic [NUM_REQUESTORS-1:0] grant
);

  localparam int IDX_W = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

  // Index of the most recent winner
  logic [IDX_W-1:0]          last_ptr;
  logic [IDX_W-1:0]          winner;
  logic [NUM_REQUESTORS-1:0] grant_next;
  logic                      found;

  // ----------------------------------------------------------
  // Rotating priority search
  // ----------------------------------------------------------
  // Starts just after the last winner and wraps around,
  // so the last winner is tried last and wins again only alone
  always_comb begin : pick
    int idx;
    grant_next = '0;
    winner     = last_ptr;
    found      = 1'b0;
    for (int off = 1; off <= NUM_REQUESTORS; off++) begin
      idx = int'(last_ptr) + off;
      if (idx >= NUM_REQUESTORS) begin
        idx = idx - NUM_REQUESTORS;
      end
      // First requesting line wins
      if (!found && request[idx]) begin
        found           = 1'b1;
        grant_next[idx] = 1'b1;
        winner          = IDX_W'(idx);
      end
    end
  end

  // ----------------------------------------------------------
  // Grant register
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant    <= '0;
      // Line 0 has first pick after reset
      last_ptr <= IDX_W'(NUM_REQUESTORS - 1);
    end else if (enable && found) begin
      grant    <= grant_next;
      last_ptr <= winner;
    end else begin
      // Disabled or idle, pointer keeps its place
      grant <= '0;
    end
  end

endmodule : round_robin_arbiter

//--- rtl/setup_timer.sv
`timescale 1ns/1ns

module setup_timer #(
  parameter int SETUP_CYCLES = 16
) (
  input  logic ap_clk,
  input  logic areset_control,
  output logic busy
);

  localparam int CNT_W = (SETUP_CYCLES > 2) ? $clog2(SETUP_CYCLES) : 1;
  // Busy drops one edge early, the FSM state register adds the last cycle
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(SETUP_CYCLES - 2);

  // Cycles since reset release
  logic [CNT_W-1:0] cnt;

  // ----------------------------------------------------------
  // Post-reset window
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      cnt  <= '0;
      busy <= 1'b1;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == LAST_CNT) begin
        busy <= 1'b0;
      end
    end
  end

endmodule : setup_timer

//--- rtl/arbiter_control_fsm.sv
`timescale 1ns/1ns

module arbiter_control_fsm (
  input  logic                 ap_clk,
  input  logic                 areset_control,
  input  logic                 setup_busy,
  input  logic                 out_prog_full,
  output glay_pkg::arb_state_t state,
  output logic                 fifo_setup,
  output logic                 arb_enable
);

  import glay_pkg::*;

  arb_state_t next_state;

  // ----------------------------------------------------------
  // State register
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= ARB_SETUP;
    end else begin
      state <= next_state;
    end
  end

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      // Wait for the FIFOs to finish clearing
      ARB_SETUP: if (!setup_busy) next_state = ARB_RUN;
      // Output FIFO nearly full, stop granting
      ARB_RUN:   if (out_prog_full) next_state = ARB_HOLD;
      // Drained below threshold
      ARB_HOLD:  if (!out_prog_full) next_state = ARB_RUN;
      default:   next_state = ARB_SETUP;
    endcase
  end

  // Moore outputs
  assign fifo_setup = (state == ARB_SETUP);
  assign arb_enable = (state == ARB_RUN);

endmodule : arbiter_control_fsm

//--- rtl/mem_request_arbiter.sv
`timescale 1ns/1ns

module mem_request_arbiter #(
  parameter int NUM_REQUESTORS  = 4,
  parameter int IN_FIFO_DEPTH   = 16,
  parameter int IN_PROG_THRESH  = 12,
  parameter int OUT_FIFO_DEPTH  = 8,
  parameter int OUT_PROG_THRESH = 4,
  parameter int SETUP_CYCLES    = 16
) (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  logic [NUM_REQUESTORS-1:0]         in_valid,
  input  glay_pkg::mem_cmd_t                in_cmd     [NUM_REQUESTORS-1:0],
  input  logic [glay_pkg::SOURCE_WIDTH-1:0] in_source  [NUM_REQUESTORS-1:0],
  input  logic [glay_pkg::ADDR_WIDTH-1:0]   in_address [NUM_REQUESTORS-1:0],
  input  logic [glay_pkg::DATA_WIDTH-1:0]   in_data    [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0]         grant,
  input  logic                              out_rd_en,
  output logic                              out_valid,
  output glay_pkg::mem_cmd_t                out_cmd,
  output logic [glay_pkg::SOURCE_WIDTH-1:0] out_source,
  output logic [glay_pkg::ADDR_WIDTH-1:0]   out_address,
  output logic [glay_pkg::DATA_WIDTH-1:0]   out_data,
  output logic                              fifo_setup
);

  import glay_pkg::*;

  // Input stage
  logic [NUM_REQUESTORS-1:0] in_valid_reg;
  logic [PACKET_WIDTH-1:0]   in_word_reg [NUM_REQUESTORS-1:0];

  // Input FIFO side
  logic [PACKET_WIDTH-1:0]   in_dout [NUM_REQUESTORS-1:0];
  logic [NUM_REQUESTORS-1:0] in_rd_valid;
  logic [NUM_REQUESTORS-1:0] in_empty;
  logic [NUM_REQUESTORS-1:0] in_prog_full;

  // Arbitration
  logic [NUM_REQUESTORS-1:0] arb_request;
  logic [NUM_REQUESTORS-1:0] arb_grant;
  logic                      arb_enable;
  logic [PACKET_WIDTH-1:0]   arb_word_sel;
  logic [PACKET_WIDTH-1:0]   arb_word_reg;
  logic                      arb_valid_reg;

  // Output FIFO side
  logic                      out_fifo_rd_en;
  logic [PACKET_WIDTH-1:0]   out_fifo_dout;
  logic                      out_fifo_valid;
  logic                      out_fifo_empty;
  logic                      out_fifo_prog_full;
  logic [PACKET_WIDTH-1:0]   out_word_reg;

  // Control
  logic                      setup_busy;
  arb_state_t                arb_state;

  // ----------------------------------------------------------
  // Setup window and controller
  // ----------------------------------------------------------
  setup_timer #(
    .SETUP_CYCLES(SETUP_CYCLES)
  ) u_setup_timer (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .busy          (setup_busy)
  );

  arbiter_control_fsm u_arbiter_control_fsm (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .setup_busy    (setup_busy),
    .out_prog_full (out_fifo_prog_full),
    .state         (arb_state),
    .fifo_setup    (fifo_setup),
    .arb_enable    (arb_enable)
  );

  // ----------------------------------------------------------
  // Input registers
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_reg <= '0;
    end else begin
      in_valid_reg <= in_valid;
    end
  end

  // Fields packed into one stored word
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      in_word_reg[i] <= {in_cmd[i], in_source[i], in_address[i], in_data[i]};
    end
  end

  // Per-requestor grant, low in setup and hold or near full
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant <= '0;
    end else begin
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        grant[i] <= (arb_state == ARB_RUN) & ~in_prog_full[i];
      end
    end
  end

  // ----------------------------------------------------------
  // Input FIFOs, one per requestor
  // ----------------------------------------------------------
  for (genvar g = 0; g < NUM_REQUESTORS; g++) begin : gen_in_fifo
    // Anything queued is a request
    assign arb_request[g] = ~in_empty[g];

    request_fifo #(
      .DEPTH      (IN_FIFO_DEPTH),
      .PROG_THRESH(IN_PROG_THRESH)
    ) u_in_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .wr_en         (in_valid_reg[g]),
      .rd_en         (arb_grant[g]),
      .din           (in_word_reg[g]),
      .dout          (in_dout[g]),
      .valid         (in_rd_valid[g]),
      .empty         (in_empty[g]),
      .full          (),
      .prog_full     (in_prog_full[g])
    );
  end

  round_robin_arbiter #(
    .NUM_REQUESTORS(NUM_REQUESTORS)
  ) u_round_robin_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .enable        (arb_enable),
    .request       (arb_request),
    .grant         (arb_grant)
  );

  // ----------------------------------------------------------
  // Winner select and arbitration register
  // ----------------------------------------------------------
  // Read valids are one-hot, an OR of masked words picks the winner
  always_comb begin
    arb_word_sel = '0;
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      arb_word_sel = arb_word_sel | (in_dout[i] & {PACKET_WIDTH{in_rd_valid[i]}});
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arb_valid_reg <= 1'b0;
    end else begin
      arb_valid_reg <= |in_rd_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    arb_word_reg <= arb_word_sel;
  end

  // ----------------------------------------------------------
  // Shared output FIFO
  // ----------------------------------------------------------
  // Pop only when something is there
  assign out_fifo_rd_en = out_rd_en & ~out_fifo_empty;

  request_fifo #(
    .DEPTH      (OUT_FIFO_DEPTH),
    .PROG_THRESH(OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (arb_valid_reg),
    .rd_en         (out_fifo_rd_en),
    .din           (arb_word_reg),
    .dout          (out_fifo_dout),
    .valid         (out_fifo_valid),
    .empty         (out_fifo_empty),
    .full          (),
    .prog_full     (out_fifo_prog_full)
  );

  // ----------------------------------------------------------
  // Output register and unpack
  // ----------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= out_fifo_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_word_reg <= out_fifo_dout;
  end

  // Fields back out of the stored word
  assign out_cmd     = mem_cmd_t'(out_word_reg[CMD_LSB +: CMD_WIDTH]);
  assign out_source  = out_word_reg[SOURCE_LSB +: SOURCE_WIDTH];
  assign out_address = out_word_reg[ADDR_LSB +: ADDR_WIDTH];
  assign out_data    = out_word_reg[DATA_LSB +: DATA_WIDTH];

endmodule : mem_request_arbiter

//--- bench/mem_request_arbiter_properties.sv
`timescale 1ns/1ns

module mem_request_arbiter_properties #(
  parameter int NUM_REQUESTORS = 4
) (
  input logic                      ap_clk,
  input logic                      areset_control,
  input glay_pkg::arb_state_t      arb_state,
  input logic                      out_valid,
  input logic                      fifo_setup,
  input logic [NUM_REQUESTORS-1:0] grant,
  input logic [NUM_REQUESTORS-1:0] arb_grant
);

  import glay_pkg::*;

  // ----------------------------------------------------------
  // Setup window
  // ----------------------------------------------------------
  // No output traffic while the FIFOs clear
  a_no_out_in_setup: assert property (@(posedge ap_clk) disable iff (areset_control)
    (arb_state == ARB_SETUP) |-> !out_valid)
    else $error("out_valid high in the setup state");

  // Requestors held off until setup ends
  a_no_grant_in_setup: assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo_setup |-> (grant == '0))
    else $error("requestor grant high while fifo_setup is high");

  // ----------------------------------------------------------
  // Arbiter
  // ----------------------------------------------------------
  // At most one FIFO popped per cycle
  a_arb_onehot: assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0(arb_grant))
    else $error("internal arbiter grant is not one-hot");

endmodule : mem_request_arbiter_properties

bind mem_request_arbiter mem_request_arbiter_properties #(
  .NUM_REQUESTORS(NUM_REQUESTORS)
) u_mem_request_arbiter_properties (
  .ap_clk        (ap_clk),
  .areset_control(areset_control),
  .arb_state     (arb_state),
  .out_valid     (out_valid),
  .fifo_setup    (fifo_setup),
  .grant         (grant),
  .arb_grant     (arb_grant)
);

//--- bench/tb_mem_request_arbiter.sv
`timescale 1ns/1ns

module tb_mem_request_arbiter;

  import glay_pkg::*;

  // ----------------------------------------------------------
  // Run constants matching the DUT defaults
  // ----------------------------------------------------------
  localparam int NUM_REQUESTORS = 4;
  localparam int SETUP_CYCLES   = 16;
  localparam int RESET_CYCLES   = 2;
  // Lines in the stimulus file
  localparam int NUM_LINES      = 28;
  // Read stall long enough to push the output FIFO into hold
  localparam int STALL_START    = SETUP_CYCLES + 4;
  localparam int STALL_LEN      = 60;
  // Per-line budget plus the setup window
  localparam int MAX_CYCLES     = NUM_LINES * 40 + SETUP_CYCLES + RESET_CYCLES;
  // Idle cycles after the drain to catch stray packets
  localparam int TAIL_CYCLES    = 20;

  logic                        ap_clk;
  logic                        areset_control = 1'b1;
  logic [NUM_REQUESTORS-1:0]   in_valid = '0;
  mem_cmd_t                    in_cmd     [NUM_REQUESTORS-1:0] = '{default: CMD_READ};
  logic [SOURCE_WIDTH-1:0]     in_source  [NUM_REQUESTORS-1:0] = '{default: '0};
  logic [ADDR_WIDTH-1:0]       in_address [NUM_REQUESTORS-1:0] = '{default: '0};
  logic [DATA_WIDTH-1:0]       in_data    [NUM_REQUESTORS-1:0] = '{default: '0};
  logic [NUM_REQUESTORS-1:0]   grant;
  logic                        out_rd_en = 1'b0;
  logic                        out_valid;
  mem_cmd_t                    out_cmd;
  logic [SOURCE_WIDTH-1:0]     out_source;
  logic [ADDR_WIDTH-1:0]       out_address;
  logic [DATA_WIDTH-1:0]       out_data;
  logic                        fifo_setup;

  // Four words per line as source, command, address and data
  logic [31:0] stim_mem [4*NUM_LINES];
  // Line numbers waiting to be pushed and pushed lines still awaited
  int push_q [NUM_REQUESTORS][$];
  int exp_q  [NUM_REQUESTORS][$];

  logic [31:0]               rng_state = 32'd88544;
  logic                      running = 1'b0;
  logic                      setup_done = 1'b0;
  int                        cycle = 0;
  int                        setup_len = 0;
  int                        line_idx;
  // Grants to other lines since each line's last own grant
  int                        wait_cnt [NUM_REQUESTORS] = '{default: 0};
  logic [NUM_REQUESTORS-1:0] req_prev = '0;

  mem_request_arbiter u_mem_request_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .in_valid      (in_valid),
    .in_cmd        (in_cmd),
    .in_source     (in_source),
    .in_address    (in_address),
    .in_data       (in_data),
    .grant         (grant),
    .out_rd_en     (out_rd_en),
    .out_valid     (out_valid),
    .out_cmd       (out_cmd),
    .out_source    (out_source),
    .out_address   (out_address),
    .out_data      (out_data),
    .fifo_setup    (fifo_setup)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Requests not yet pushed or not yet seen at the output
  function automatic int outstanding();
    int n;
    n = 0;
    for (int s = 0; s < NUM_REQUESTORS; s++) begin
      n = n + push_q[s].size() + exp_q[s].size();
    end
    return n;
  endfunction

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_cmd(input string name, input mem_cmd_t expected, input mem_cmd_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %s actual %s", name, expected.name(), actual.name());
      stop_on_error();
    end
  endtask

  task automatic check_word(input string name, input logic [ADDR_WIDTH-1:0] expected,
                            input logic [ADDR_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %08h actual %08h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("** Error %s: expected %0d actual %0d", name, expected, actual);
      stop_on_error();
    end
  endtask

  // Splits the file lines into per-source queues
  task automatic load_stimulus();
    int src;
    $readmemh("bench/stim_requests.txt", stim_mem);
    for (int k = 0; k < NUM_LINES; k++) begin
      src = int'(stim_mem[4*k]);
      if ($isunknown(stim_mem[4*k+3]) || src >= NUM_REQUESTORS) begin
        $display("Stimulus line %0d is missing or names a bad source", k);
        stop_on_error();
      end
      push_q[src].push_back(k);
    end
  endtask

  // Setup level length and quiet outputs inside it
  task automatic watch_setup_window();
    if (!setup_done) begin
      if (fifo_setup === 1'b1) begin
        setup_len++;
        if (grant !== '0 || out_valid !== 1'b0) begin
          $display("Grant or out_valid seen while fifo_setup is high");
          stop_on_error();
        end
      end else begin
        check_count("setup window length", SETUP_CYCLES, setup_len);
        setup_done = 1'b1;
      end
    end else if (fifo_setup !== 1'b0) begin
      $display("fifo_setup rose again after the setup window");
      stop_on_error();
    end
  endtask

  // Scoreboard in file order per source
  task automatic score_output();
    int    src;
    int    idx;
    string tag;
    if (out_valid === 1'b1) begin
      src = int'(out_source);
      if (src >= NUM_REQUESTORS || exp_q[src].size() == 0) begin
        $display("Packet from source %0d arrived with nothing pending from it", src);
        stop_on_error();
      end else begin
        idx = exp_q[src].pop_front();
        tag = $sformatf("source %0d line %0d", src, idx);
        check_cmd({tag, " command"}, mem_cmd_t'(stim_mem[4*idx+1][1:0]), out_cmd);
        check_word({tag, " address"}, stim_mem[4*idx+2], out_address);
        check_word({tag, " data"}, stim_mem[4*idx+3], out_data);
      end
    end else if (out_valid !== 1'b0) begin
      $display("out_valid is unknown after reset");
      stop_on_error();
    end
  endtask

  // Grant seen now was decided from last edge's requests
  task automatic track_fairness();
    logic [NUM_REQUESTORS-1:0] gnt;
    gnt = u_mem_request_arbiter.arb_grant;
    for (int s = 0; s < NUM_REQUESTORS; s++) begin
      if (gnt[s]) begin
        wait_cnt[s] = 0;
      end else if (!req_prev[s]) begin
        // Line went empty so its wait starts over
        wait_cnt[s] = 0;
      end else if (gnt != '0) begin
        wait_cnt[s]++;
        if (wait_cnt[s] > NUM_REQUESTORS - 1) begin
          $display("Source %0d waited behind %0d grants to others", s, wait_cnt[s]);
          stop_on_error();
        end
      end
    end
    req_prev = u_mem_request_arbiter.arb_request;
  endtask

  // ----------------------------------------------------------
  // Per-cycle monitor and drivers
  // ----------------------------------------------------------
  always @(posedge ap_clk) begin
    if (running) begin
      cycle++;
      if (cycle > MAX_CYCLES) begin
        $display("Timeout with %0d requests outstanding after %0d cycles", outstanding(), cycle);
        stop_on_error();
      end
      watch_setup_window();
      score_output();
      track_fairness();
      // Output FIFO in hold by now and every grant down
      if (cycle == STALL_START + STALL_LEN && grant !== '0) begin
        $display("Grants still high at the end of the read stall");
        stop_on_error();
      end
      // Each source pushes its next line on a granted random draw
      for (int s = 0; s < NUM_REQUESTORS; s++) begin
        rng_state = xorshift32(rng_state);
        if (grant[s] && !fifo_setup && push_q[s].size() > 0 && rng_state[1:0] != 2'b00) begin
          line_idx = push_q[s].pop_front();
          exp_q[s].push_back(line_idx);
          in_valid[s]   <= 1'b1;
          in_cmd[s]     <= mem_cmd_t'(stim_mem[4*line_idx+1][1:0]);
          in_source[s]  <= stim_mem[4*line_idx][SOURCE_WIDTH-1:0];
          in_address[s] <= stim_mem[4*line_idx+2];
          in_data[s]    <= stim_mem[4*line_idx+3];
        end else begin
          in_valid[s] <= 1'b0;
        end
      end
      // Memory side pops with one long stall
      rng_state = xorshift32(rng_state);
      if (cycle >= STALL_START && cycle < STALL_START + STALL_LEN) begin
        out_rd_en <= 1'b0;
      end else begin
        out_rd_en <= rng_state[0] | rng_state[1];
      end
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    load_stimulus();
    repeat (RESET_CYCLES) @(posedge ap_clk);
    // State left by the first reset edge
    if (fifo_setup !== 1'b1 || grant !== '0 || out_valid !== 1'b0 ||
        u_mem_request_arbiter.arb_grant !== '0 ||
        u_mem_request_arbiter.in_rd_valid !== '0 ||
        u_mem_request_arbiter.out_fifo_valid !== 1'b0) begin
      $display("Outputs not at their reset values while areset_control is high");
      stop_on_error();
    end
    areset_control <= 1'b0;
    running        <= 1'b1;
    while (outstanding() != 0) begin
      @(posedge ap_clk);
    end
    repeat (TAIL_CYCLES) @(posedge ap_clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule : tb_mem_request_arbiter

//--- bench/stim_requests.txt
// Columns: source, command (0 read, 1 write, 2 read stream, 3 write stream),
// address, data; all hex, one request per line
0 0 00001000 a0000001
1 1 00002000 b0000001
2 2 00003000 c0000001
3 3 00004000 d0000001
0 1 00001040 a0000002
0 2 00001080 a0000003
1 0 00002040 b0000002
3 1 00004040 d0000002
2 3 00003040 c0000002
1 3 00002080 b0000003
2 0 00003080 c0000003
3 2 00004080 d0000003
0 3 000010c0 a0000004
1 2 000020c0 b0000004
2 1 000030c0 c0000004
3 0 000040c0 d0000004
0 0 00001100 a0000005
2 2 00003100 c0000005
1 1 00002100 b0000005
3 3 00004100 d0000005
0 1 00001140 a0000006
1 0 00002140 b0000006
2 3 00003140 c0000006
3 2 00004140 d0000006
3 1 00004180 d0000007
2 0 00003180 c0000007
1 2 00002180 b0000007
0 3 00001180 a0000007

//--- tb.f
rtl/glay_pkg.sv
rtl/request_fifo.sv
rtl/round_robin_arbiter.sv
rtl/setup_timer.sv
rtl/arbiter_control_fsm.sv
rtl/mem_request_arbiter.sv
bench/mem_request_arbiter_properties.sv
bench/tb_mem_request_arbiter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory request arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_request_arbiter \
  -f tb.f \
  -o sim_tb

sim_status=0
./obj_dir/sim_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

echo "Simulation passed"
